//--- cart_map_pkg.sv
package cart_map_pkg;

    // ########################################################################
    // Address widths

    localparam int PRG_ADDR_BITS = 19;  // 512 KiB of PRG
    localparam int CHR_ADDR_BITS = 17;  // 128 KiB of CHR
    localparam int PRG_BANK_BITS = 14;  // Offset inside one 16 KiB PRG bank
    localparam int CHR_BANK_BITS = 13;  // Offset inside one 8 KiB CHR bank
    localparam logic [4:0] PRG_SIZE_LOG2_MAX = 5'd5;  // 32 banks of 16 KiB

    // ########################################################################
    // Encodings

    typedef enum logic [4:0] {
        MAP_NONE  = 5'd0,
        MAP_NROM  = 5'd1,
        MAP_UXROM = 5'd2,
        MAP_CNROM = 5'd3
    } map_id_e;

    typedef enum logic [3:0] {
        REG_MAPPER = 4'd0,
        REG_CLEAR  = 4'd1
    } host_reg_e;

    // ########################################################################
    // Bundles

    // Field order matches bits 11:0 of the host configuration word
    typedef struct packed {
        logic chr_ram;
        logic mirroring;              // Vertical when set
        logic [4:0] prg_size_log2;    // Number of 16 KiB banks as a power of two
        map_id_e select;
    } map_cfg_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0] data;
        logic rw;
        logic m2;
    } cpu_bus_t;

    typedef struct packed {
        logic [4:0] prg_bank;
        logic [1:0] chr_bank;
        logic bank_valid;
    } bank_t;

    typedef struct packed {
        logic [PRG_ADDR_BITS-1:0] prg_addr;
        logic prg_oe;
        logic [CHR_ADDR_BITS-1:0] chr_addr;
        logic chr_ce;
        logic chr_oe;
        logic chr_we;
    } mem_req_t;

    // Highest PRG bank number for a cart of 2**size_log2 banks
    function automatic logic [4:0] prg_bank_mask(input logic [4:0] size_log2);
        logic [5:0] banks;
        banks = 6'd1 << size_log2;
        return 5'(banks - 6'd1);
    endfunction

endpackage

//--- host_reg_decode.sv
`timescale 1ns/100ps

module host_reg_decode (
    input logic clk,
    input logic async_reset,
    input logic [31:0] wr_reg,
    input cart_map_pkg::host_reg_e wr_reg_addr,
    input logic wr_reg_changed,
    output cart_map_pkg::map_cfg_t cfg,
    output logic bank_clear,
    output logic [31:0] status
);
    import cart_map_pkg::*;

    logic [2:0] wr_sync;
    logic wr_strobe;
    map_cfg_t new_cfg;

    // ########################################################################
    // Host strobe synchronizer

    always_ff @(posedge clk or posedge async_reset) begin
        if (async_reset) begin
            wr_sync <= '0;
        end else begin
            wr_sync <= {wr_sync[1:0], wr_reg_changed};
        end
    end

    assign wr_strobe = wr_sync[1] != wr_sync[2];  // Either toggle direction is a write

    // ########################################################################
    // Register decode

    always_comb begin
        new_cfg = map_cfg_t'(wr_reg[11:0]);
        if (new_cfg.prg_size_log2 > PRG_SIZE_LOG2_MAX) begin
            new_cfg.prg_size_log2 = PRG_SIZE_LOG2_MAX;  // Larger than the PRG memory
        end
    end

    always_ff @(posedge clk or posedge async_reset) begin
        if (async_reset) begin
            cfg <= '0;
            bank_clear <= 1'b0;
        end else begin
            bank_clear <= 1'b0;
            if (wr_strobe) begin
                case (wr_reg_addr)
                    REG_MAPPER: cfg <= new_cfg;
                    REG_CLEAR: bank_clear <= 1'b1;
                    default: ;  // Unknown registers are ignored
                endcase
            end
        end
    end

    assign status = {20'd0, cfg};

    // A single host toggle must give a single clear pulse downstream
    bank_clear_pulse: assert property (
        @(posedge clk) disable iff (async_reset)
        bank_clear |=> !bank_clear
    ) else $error("bank_clear held for more than one cycle");

endmodule

//--- mapper_bank.sv
`timescale 1ns/100ps

module mapper_bank (
    input logic clk,
    input logic async_reset,
    input cart_map_pkg::cpu_bus_t cpu,
    input cart_map_pkg::map_cfg_t cfg,
    input logic bank_clear,
    output cart_map_pkg::bank_t bank
);
    import cart_map_pkg::*;

    logic [2:0] m2_sync;
    logic m2_fall;
    logic cpu_write;
    logic [4:0] size_mask;
    logic [4:0] prg_bank;
    logic [1:0] chr_bank;
    map_cfg_t cfg_q;
    logic select_changed;
    logic size_changed;
    logic known_mapper;

    // ########################################################################
    // CPU cycle end detection

    always_ff @(posedge clk or posedge async_reset) begin
        if (async_reset) begin
            m2_sync <= '0;
        end else begin
            m2_sync <= {m2_sync[1:0], cpu.m2};
        end
    end

    assign m2_fall = m2_sync[2] && !m2_sync[1];  // Seen between stages 2 and 3

    // Registers live at 8000 and up; address and data are still held by the CPU
    assign cpu_write = m2_fall && !cpu.rw && cpu.addr[15];

    // ########################################################################
    // Configuration tracking

    always_ff @(posedge clk or posedge async_reset) begin
        if (async_reset) begin
            cfg_q <= '0;
        end else begin
            cfg_q <= cfg;
        end
    end

    assign select_changed = cfg.select != cfg_q.select;
    assign size_changed = cfg.prg_size_log2 != cfg_q.prg_size_log2;
    assign size_mask = prg_bank_mask(cfg.prg_size_log2);
    assign known_mapper = cfg.select inside {MAP_NROM, MAP_UXROM, MAP_CNROM};

    // ########################################################################
    // Bank registers

    always_ff @(posedge clk or posedge async_reset) begin
        if (async_reset) begin
            prg_bank <= '0;
            chr_bank <= '0;
        end else if (bank_clear || select_changed) begin
            prg_bank <= '0;  // A newly selected mapper starts from bank 0
            chr_bank <= '0;
        end else if (cpu_write) begin
            case (cfg.select)
                MAP_UXROM: prg_bank <= cpu.data[4:0] & size_mask;
                MAP_CNROM: chr_bank <= cpu.data[1:0];
                default: ;  // NROM has no bank register
            endcase
        end else if (size_changed) begin
            prg_bank <= prg_bank & size_mask;  // Keep the bank inside a smaller cart
        end
    end

    assign bank = '{prg_bank: prg_bank, chr_bank: chr_bank, bank_valid: known_mapper};

    // Once the configuration has settled the bank must fit the PRG size
    prg_bank_in_size: assert property (
        @(posedge clk) disable iff (async_reset)
        (cfg == cfg_q) |-> ((prg_bank & ~size_mask) == 5'd0)
    ) else $error("prg_bank %0d outside mask %0h", prg_bank, size_mask);

endmodule

//--- cart_bus_mux.sv
`timescale 1ns/100ps

module cart_bus_mux (
    input logic clk,
    input logic async_reset,
    input cart_map_pkg::cpu_bus_t cpu,
    input cart_map_pkg::map_cfg_t cfg,
    input cart_map_pkg::bank_t bank,
    input logic [13:0] ppu_addr,
    input logic ppu_rd,
    input logic ppu_wr,
    input logic [7:0] prg_rdata,
    input logic [7:0] chr_rdata,
    output cart_map_pkg::mem_req_t mem,
    output logic [7:0] cpu_data_out,
    output logic [7:0] ppu_data_out,
    output logic cpu_oe,
    output logic ppu_oe,
    output logic ciram_a10,
    output logic ciram_ce
);
    import cart_map_pkg::*;

    logic [4:0] bank_mask;
    logic [4:0] uxrom_bank;
    logic [PRG_ADDR_BITS-1:0] prg_mask;
    logic [PRG_ADDR_BITS-1:0] prg_linear;
    logic [PRG_ADDR_BITS-1:0] prg_banked;
    logic chr_ce;
    logic chr_oe;
    logic chr_we;

    // ########################################################################
    // PRG address

    assign bank_mask = prg_bank_mask(cfg.prg_size_log2);
    assign prg_mask = {bank_mask, {PRG_BANK_BITS{1'b1}}};

    // A 16 KiB cart mirrors its only bank across 8000 to FFFF
    assign prg_linear = PRG_ADDR_BITS'(cpu.addr[14:0]) & prg_mask;

    assign uxrom_bank = cpu.addr[14] ? bank_mask : bank.prg_bank;  // C000 and up is fixed
    assign prg_banked = {uxrom_bank, cpu.addr[PRG_BANK_BITS-1:0]} & prg_mask;

    // ########################################################################
    // Memory request

    always_comb begin
        case (cfg.select)
            MAP_UXROM: mem.prg_addr = prg_banked;
            MAP_NROM, MAP_CNROM: mem.prg_addr = prg_linear;
            default: mem.prg_addr = '0;
        endcase

        if (cfg.select == MAP_CNROM) begin
            mem.chr_addr = CHR_ADDR_BITS'({bank.chr_bank, ppu_addr[CHR_BANK_BITS-1:0]});
        end else begin
            mem.chr_addr = CHR_ADDR_BITS'(ppu_addr[CHR_BANK_BITS-1:0]);
        end

        mem.prg_oe = cpu_oe;
        mem.chr_ce = chr_ce;
        mem.chr_oe = chr_oe;
        mem.chr_we = chr_we;
    end

    // ########################################################################
    // Cart bus controls

    assign cpu_oe = cpu.m2 && cpu.rw && cpu.addr[15] && bank.bank_valid;
    assign cpu_data_out = prg_rdata;

    assign chr_ce = !ppu_addr[13] && bank.bank_valid;  // Pattern tables below 2000
    assign chr_oe = chr_ce && ppu_rd;
    assign chr_we = chr_ce && ppu_wr && cfg.chr_ram;
    assign ppu_oe = chr_ce && chr_oe;
    assign ppu_data_out = chr_rdata;

    assign ciram_ce = !(ppu_addr[13] && bank.bank_valid);  // Active low
    assign ciram_a10 = cfg.mirroring ? ppu_addr[10] : ppu_addr[11];

    chr_we_needs_ram: assert property (
        @(posedge clk) disable iff (async_reset)
        chr_we |-> cfg.chr_ram
    ) else $error("CHR write strobe with CHR ROM configured");

    cpu_oe_on_read: assert property (
        @(posedge clk) disable iff (async_reset)
        cpu_oe |-> cpu.rw
    ) else $error("Cart drives CPU data during a CPU write");

endmodule

//--- cart_map_top.sv
`timescale 1ns/100ps

module cart_map_top (
    input logic clk,
    input logic async_reset,
    input logic m2,
    input logic [15:0] cpu_addr,
    input logic [7:0] cpu_data_in,
    input logic cpu_rw,
    output logic [7:0] cpu_data_out,
    output logic cpu_oe,
    input logic [13:0] ppu_addr,
    input logic ppu_rd,
    input logic ppu_wr,
    input logic [7:0] ppu_data_in,
    output logic [7:0] ppu_data_out,
    output logic ppu_oe,
    output logic ciram_a10,
    output logic ciram_ce,
    input logic [31:0] wr_reg,
    input cart_map_pkg::host_reg_e wr_reg_addr,
    input logic wr_reg_changed,
    output logic [31:0] status,
    output cart_map_pkg::mem_req_t mem,
    output logic [7:0] chr_wdata,     // CHR RAM write data from the PPU
    input logic [7:0] prg_rdata,
    input logic [7:0] chr_rdata
);
    import cart_map_pkg::*;

    cpu_bus_t cpu_bus;
    map_cfg_t cfg;
    bank_t bank;
    logic bank_clear;

    assign cpu_bus = '{addr: cpu_addr, data: cpu_data_in, rw: cpu_rw, m2: m2};
    assign chr_wdata = ppu_data_in;

    host_reg_decode host_reg_decode (
        .clk(clk),
        .async_reset(async_reset),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .cfg(cfg),
        .bank_clear(bank_clear),
        .status(status)
    );

    mapper_bank mapper_bank (
        .clk(clk),
        .async_reset(async_reset),
        .cpu(cpu_bus),
        .cfg(cfg),
        .bank_clear(bank_clear),
        .bank(bank)
    );

    cart_bus_mux cart_bus_mux (
        .clk(clk),
        .async_reset(async_reset),
        .cpu(cpu_bus),
        .cfg(cfg),
        .bank(bank),
        .ppu_addr(ppu_addr),
        .ppu_rd(ppu_rd),
        .ppu_wr(ppu_wr),
        .prg_rdata(prg_rdata),
        .chr_rdata(chr_rdata),
        .mem(mem),
        .cpu_data_out(cpu_data_out),
        .ppu_data_out(ppu_data_out),
        .cpu_oe(cpu_oe),
        .ppu_oe(ppu_oe),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce)
    );

endmodule

//--- tb_cart_check.sv
`timescale 1ns/100ps

module tb_cart_check (
    input logic clk,
    input logic check_status,
    input logic check_bus,
    input int step_num,
    input logic [31:0] exp_status,
    input logic [cart_map_pkg::PRG_ADDR_BITS-1:0] exp_prg_addr,
    input logic [cart_map_pkg::CHR_ADDR_BITS-1:0] exp_chr_addr,
    input logic [6:0] exp_flags,
    input logic [31:0] status,
    input cart_map_pkg::mem_req_t mem,
    input logic cpu_oe,
    input logic ppu_oe,
    input logic ciram_ce,
    input logic ciram_a10,
    input logic [7:0] cpu_data_out,
    input logic [7:0] ppu_data_out,
    input logic [7:0] chr_wdata,
    input logic [7:0] ppu_data_in,
    input logic [7:0] prg_rdata,
    input logic [7:0] chr_rdata,
    output int pass_count,
    output int fail_count
);
    import cart_map_pkg::*;

    int errors;
    int passed = 0;
    int failed = 0;

    assign pass_count = passed;
    assign fail_count = failed;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ########################################################################
    // Sampling on the falling edge, half a cycle after the drive

    always @(negedge clk) begin
        if (check_status || check_bus) begin
            errors = 0;
            compare_value("status", status, exp_status);
            if (check_bus) begin
                compare_value("prg_addr", 32'(mem.prg_addr), 32'(exp_prg_addr));
                compare_value("chr_addr", 32'(mem.chr_addr), 32'(exp_chr_addr));
                compare_value("cpu_oe", 32'(cpu_oe), 32'(exp_flags[6]));
                compare_value("prg_oe", 32'(mem.prg_oe), 32'(exp_flags[6]));
                compare_value("chr_ce", 32'(mem.chr_ce), 32'(exp_flags[5]));
                compare_value("chr_oe", 32'(mem.chr_oe), 32'(exp_flags[4]));
                compare_value("chr_we", 32'(mem.chr_we), 32'(exp_flags[3]));
                compare_value("ppu_oe", 32'(ppu_oe), 32'(exp_flags[2]));
                compare_value("ciram_ce", 32'(ciram_ce), 32'(exp_flags[1]));
                compare_value("ciram_a10", 32'(ciram_a10), 32'(exp_flags[0]));
                // Read data goes straight from memory to the cart bus
                compare_value("cpu_data_out", 32'(cpu_data_out), 32'(prg_rdata));
                compare_value("ppu_data_out", 32'(ppu_data_out), 32'(chr_rdata));
                compare_value("chr_wdata", 32'(chr_wdata), 32'(ppu_data_in));
            end
            if (errors == 0) begin
                passed++;
                $display("test %0d: pass", step_num);
            end else begin
                failed++;
                $display("test %0d: FAIL with %0d mismatches", step_num, errors);
            end
        end
    end

endmodule

//--- tb_cart_map.sv
`timescale 1ns/100ps

module tb_cart_map;
    import cart_map_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_STEP = 12;  // Longest step is a CPU write of 9 cycles
    localparam int MARGIN_CYCLES = 50;

    typedef enum logic [1:0] {
        STEP_HOST,
        STEP_CPU_WRITE,
        STEP_PROBE
    } step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        logic [31:0] word;
        host_reg_e reg_addr;
        logic [3:0] ctl;                        // {m2, cpu_rw, ppu_rd, ppu_wr}
        logic [15:0] cpu_addr;
        logic [7:0] cpu_data;
        logic [13:0] ppu_addr;
        logic [31:0] exp_status;
        logic [PRG_ADDR_BITS-1:0] exp_prg_addr;
        logic [CHR_ADDR_BITS-1:0] exp_chr_addr;
        logic [6:0] exp_flags;                  // {cpu_oe, chr ce/oe/we, ppu_oe, ciram_ce, a10}
    } step_t;

    logic clk = 1'b0;
    logic async_reset;
    logic m2, cpu_rw, ppu_rd, ppu_wr, wr_reg_changed;
    logic [15:0] cpu_addr;
    logic [7:0] cpu_data_in, ppu_data_in;
    logic [13:0] ppu_addr;
    logic [31:0] wr_reg;
    host_reg_e wr_reg_addr;
    logic [7:0] prg_rdata = 8'h00;
    logic [7:0] chr_rdata = 8'h00;
    logic [7:0] cpu_data_out, ppu_data_out, chr_wdata;
    logic cpu_oe, ppu_oe, ciram_a10, ciram_ce;
    logic [31:0] status;
    mem_req_t mem;

    step_t steps[$];
    logic [31:0] cur_status = 32'd0;
    logic check_status = 1'b0;
    logic check_bus = 1'b0;
    int step_num = 0;
    logic [31:0] exp_status = 32'd0;
    logic [PRG_ADDR_BITS-1:0] exp_prg_addr = '0;
    logic [CHR_ADDR_BITS-1:0] exp_chr_addr = '0;
    logic [6:0] exp_flags = '0;
    int pass_count, fail_count;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic [7:0] prg_key, chr_key;

    always #4 clk = ~clk;

    cart_map_top DUT (
        .clk(clk), .async_reset(async_reset),
        .m2(m2), .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .cpu_rw(cpu_rw),
        .cpu_data_out(cpu_data_out), .cpu_oe(cpu_oe),
        .ppu_addr(ppu_addr), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr), .ppu_data_in(ppu_data_in),
        .ppu_data_out(ppu_data_out), .ppu_oe(ppu_oe),
        .ciram_a10(ciram_a10), .ciram_ce(ciram_ce),
        .wr_reg(wr_reg), .wr_reg_addr(wr_reg_addr), .wr_reg_changed(wr_reg_changed),
        .status(status), .mem(mem), .chr_wdata(chr_wdata),
        .prg_rdata(prg_rdata), .chr_rdata(chr_rdata)
    );

    tb_cart_check bus_checker (
        .clk(clk), .check_status(check_status), .check_bus(check_bus),
        .step_num(step_num), .exp_status(exp_status), .exp_prg_addr(exp_prg_addr),
        .exp_chr_addr(exp_chr_addr), .exp_flags(exp_flags),
        .status(status), .mem(mem), .cpu_oe(cpu_oe), .ppu_oe(ppu_oe),
        .ciram_ce(ciram_ce), .ciram_a10(ciram_a10),
        .cpu_data_out(cpu_data_out), .ppu_data_out(ppu_data_out),
        .chr_wdata(chr_wdata), .ppu_data_in(ppu_data_in),
        .prg_rdata(prg_rdata), .chr_rdata(chr_rdata),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    // Every address bit lands somewhere in the byte
    function automatic logic [7:0] fill_byte(input logic [7:0] key, input logic [18:0] addr);
        return key ^ addr[7:0] ^ {addr[10:8], addr[15:11]} ^ {5'd0, addr[18:16]};
    endfunction

    always @(posedge clk) begin
        prg_rdata <= fill_byte(prg_key, mem.prg_addr);
        chr_rdata <= fill_byte(chr_key, 19'(mem.chr_addr));
    end

    // ########################################################################
    // Stimulus table

    function automatic void add_host_write(input logic [31:0] word, input host_reg_e addr,
                                           input logic [31:0] exp_stat);
        step_t s;
        s = '0;
        s.kind = STEP_HOST;
        s.word = word;
        s.reg_addr = addr;
        s.exp_status = exp_stat;
        cur_status = exp_stat;
        steps.push_back(s);
    endfunction

    function automatic void add_bus_step(input step_kind_e kind, input logic [3:0] ctl,
                                         input logic [15:0] addr, input logic [7:0] data,
                                         input logic [13:0] paddr,
                                         input logic [PRG_ADDR_BITS-1:0] prg,
                                         input logic [CHR_ADDR_BITS-1:0] chr,
                                         input logic [6:0] flags);
        step_t s;
        s = '0;
        s.kind = kind;
        s.ctl = ctl;
        s.cpu_addr = addr;
        s.cpu_data = data;
        s.ppu_addr = paddr;
        s.exp_status = cur_status;
        s.exp_prg_addr = prg;
        s.exp_chr_addr = chr;
        s.exp_flags = flags;
        steps.push_back(s);
    endfunction

    // Columns: kind, {m2,rw,rd,wr}, cpu addr, cpu data, ppu addr, prg addr, chr addr, flags
    function automatic void build_table();
        add_bus_step(STEP_PROBE, 4'b1111, 16'h8000, 8'h00, 14'h0800, 19'h0, 17'h00800, 7'b0000011);
        add_host_write(32'h001, REG_MAPPER, 32'h001);  // NROM 16 KiB
        add_bus_step(STEP_PROBE, 4'b1100, 16'hC123, 8'h00, 14'h0000, 19'h00123, 17'h0, 7'b1100010);
        add_bus_step(STEP_PROBE, 4'b0100, 16'h8123, 8'h00, 14'h0000, 19'h00123, 17'h0, 7'b0100010);
        add_host_write(32'h021, REG_MAPPER, 32'h021);  // NROM 32 KiB
        add_bus_step(STEP_PROBE, 4'b1100, 16'hC123, 8'h00, 14'h0000, 19'h04123, 17'h0, 7'b1100010);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h6000, 8'h00, 14'h0000, 19'h06000, 17'h0, 7'b0100010);
        add_bus_step(STEP_PROBE, 4'b1000, 16'h8010, 8'h00, 14'h0000, 19'h00010, 17'h0, 7'b0100010);
        add_bus_step(STEP_CPU_WRITE, 4'b0, 16'h8000, 8'h03, 14'h0000, 19'h0, 17'h0, 7'b0100010);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h8005, 8'h00, 14'h0000, 19'h00005, 17'h0, 7'b1100010);
        add_host_write(32'h062, REG_MAPPER, 32'h062);  // UxROM 128 KiB
        add_bus_step(STEP_PROBE, 4'b1100, 16'h8123, 8'h00, 14'h0000, 19'h00123, 17'h0, 7'b1100010);
        add_bus_step(STEP_PROBE, 4'b1100, 16'hC456, 8'h00, 14'h0000, 19'h1C456, 17'h0, 7'b1100010);
        add_bus_step(STEP_CPU_WRITE, 4'b0, 16'h8000, 8'h0D, 14'h0000, 19'h14000, 17'h0, 7'b0100010);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h9ABC, 8'h00, 14'h0000, 19'h15ABC, 17'h0, 7'b1100010);
        add_bus_step(STEP_PROBE, 4'b1100, 16'hFFFC, 8'h00, 14'h0000, 19'h1FFFC, 17'h0, 7'b1100010);
        add_host_write(32'h423, REG_MAPPER, 32'h423);  // CNROM, vertical mirroring
        add_bus_step(STEP_CPU_WRITE, 4'b0, 16'h8000, 8'hFE, 14'h0ABC, 19'h0, 17'h04ABC, 7'b0100010);
        add_bus_step(STEP_PROBE, 4'b1110, 16'h8000, 8'h00, 14'h1ABC, 19'h0, 17'h05ABC, 7'b1110110);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h8000, 8'h00, 14'h1ABC, 19'h0, 17'h05ABC, 7'b1100010);
        add_bus_step(STEP_PROBE, 4'b1101, 16'h8000, 8'h00, 14'h0400, 19'h0, 17'h04400, 7'b1100011);
        add_host_write(32'h821, REG_MAPPER, 32'h821);  // NROM with CHR RAM
        add_bus_step(STEP_PROBE, 4'b0101, 16'h8000, 8'h00, 14'h0400, 19'h0, 17'h00400, 7'b0101010);
        add_bus_step(STEP_PROBE, 4'b0111, 16'h8000, 8'h00, 14'h2C00, 19'h0, 17'h00C00, 7'b0000001);
        add_host_write(32'hC21, REG_MAPPER, 32'hC21);
        add_bus_step(STEP_PROBE, 4'b0100, 16'h8000, 8'h00, 14'h2800, 19'h0, 17'h00800, 7'b0000000);
        add_bus_step(STEP_PROBE, 4'b0100, 16'h8000, 8'h00, 14'h2400, 19'h0, 17'h00400, 7'b0000001);
        add_host_write(32'h0E1, REG_MAPPER, 32'h0A1);  // PRG size 7 clamps to 5
        add_bus_step(STEP_PROBE, 4'b1100, 16'hC123, 8'h00, 14'h0000, 19'h04123, 17'h0, 7'b1100010);
        add_host_write(32'h062, REG_MAPPER, 32'h062);
        add_bus_step(STEP_CPU_WRITE, 4'b0, 16'h8000, 8'h06, 14'h0000, 19'h18000, 17'h0, 7'b0100010);
        add_host_write(32'h000, REG_CLEAR, 32'h062);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h8000, 8'h00, 14'h0000, 19'h0, 17'h0, 7'b1100010);
        add_bus_step(STEP_CPU_WRITE, 4'b0, 16'h8000, 8'h04, 14'h0000, 19'h10000, 17'h0, 7'b0100010);
        add_host_write(32'h023, REG_MAPPER, 32'h023);
        add_host_write(32'h062, REG_MAPPER, 32'h062);
        add_bus_step(STEP_PROBE, 4'b1100, 16'h8000, 8'h00, 14'h0000, 19'h0, 17'h0, 7'b1100010);
        add_host_write(32'h067, REG_MAPPER, 32'h067);  // Unknown mapper number
        add_bus_step(STEP_PROBE, 4'b1111, 16'h8000, 8'h00, 14'h2000, 19'h0, 17'h0, 7'b0000010);
        add_bus_step(STEP_PROBE, 4'b1111, 16'hC000, 8'h00, 14'h0000, 19'h0, 17'h0, 7'b0000010);
    endfunction

    // ########################################################################
    // Step sequencing

    task automatic run_step(input step_t s, input int idx);
        @(posedge clk);
        step_num <= idx;
        exp_status <= s.exp_status;
        exp_prg_addr <= s.exp_prg_addr;
        exp_chr_addr <= s.exp_chr_addr;
        exp_flags <= s.exp_flags;
        case (s.kind)
            STEP_HOST: begin
                wr_reg <= s.word;
                wr_reg_addr <= s.reg_addr;
                wr_reg_changed <= ~wr_reg_changed;
                repeat (3) @(posedge clk);  // Synchronizer plus compare
                check_status <= 1'b1;
                @(posedge clk);
                check_status <= 1'b0;
                repeat (3) @(posedge clk);  // Let bank clears settle
            end
            STEP_CPU_WRITE: begin
                m2 <= 1'b1;
                cpu_rw <= 1'b0;
                cpu_addr <= s.cpu_addr;
                cpu_data_in <= s.cpu_data;
                ppu_addr <= s.ppu_addr;
                ppu_rd <= 1'b0;
                ppu_wr <= 1'b0;
                repeat (4) @(posedge clk);
                m2 <= 1'b0;
                repeat (3) @(posedge clk);  // Bank register is due now
                check_status <= 1'b1;
                check_bus <= 1'b1;
                @(posedge clk);
                check_status <= 1'b0;
                check_bus <= 1'b0;
            end
            default: begin
                {m2, cpu_rw, ppu_rd, ppu_wr} <= s.ctl;
                cpu_addr <= s.cpu_addr;
                ppu_addr <= s.ppu_addr;
                ppu_data_in <= 8'(idx * 7) ^ chr_key;  // PPU write data differs per step
                check_status <= 1'b1;
                check_bus <= 1'b1;
                @(posedge clk);
                check_status <= 1'b0;
                check_bus <= 1'b0;
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        integer seed;
        seed = 32'h2238d35f;
        prg_key = 8'($random(seed));
        chr_key = 8'($random(seed));
        async_reset = 1'b1;
        {m2, cpu_rw, ppu_rd, ppu_wr} = 4'b0100;
        cpu_addr = 16'h0000;
        cpu_data_in = 8'h00;
        ppu_addr = 14'h0000;
        ppu_data_in = 8'h00;
        wr_reg = 32'd0;
        wr_reg_addr = REG_MAPPER;
        wr_reg_changed = 1'b0;
        build_table();
        cycle_limit = steps.size() * CYCLES_PER_STEP + RESET_CYCLES + MARGIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        async_reset <= 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i], i);
        end
        repeat (2) @(posedge clk);
        $display("tests run %0d, passed %0d, failed %0d", steps.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count == steps.size()) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- cart_map.f
cart_map_pkg.sv
host_reg_decode.sv
mapper_bank.sv
cart_bus_mux.sv
cart_map_top.sv
tb_cart_check.sv
tb_cart_map.sv

//--- Makefile
# Verilator simulation of the cartridge mapper switch

VERILATOR ?= verilator
TOP       ?= tb_cart_map
FILELIST  ?= cart_map.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
